// ==== Makefile ====
sim:
	verilator --binary --timing --assert -Wno-fatal --top-module sifhTb -f flist.f -Mdir obj_dir
	./obj_dir/VsifhTb | tee sim.log
	! grep -q "=== FAIL ===" sim.log
	grep -q "=== PASS ===" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

// ==== flist.f ====
hw/sifhPkg.sv
hw/stampIngest.sv
hw/stampFifo.sv
hw/histRam.sv
hw/histogramFsm.sv
hw/sifhTop.sv
testbench/sifhTb.sv

// ==== hw/histRam.sv ====
`default_nettype none

module histRam #(
    parameter int pixelCount = 4,
    parameter int binBits = sifhPkg::binBitsDef,
    parameter int countBits = sifhPkg::countBitsDef,
    localparam int addrBits = $clog2(pixelCount) + binBits,
    localparam int depth = pixelCount << binBits
) (
    input  wire logic                 clk,
    input  wire logic                 rdEn,
    input  wire logic [addrBits-1:0]  rdAddr,
    output logic [countBits-1:0]      rdData,
    input  wire logic                 wrEn,
    input  wire logic [addrBits-1:0]  wrAddr,
    input  wire logic [countBits-1:0] wrData
);

    // one word per pixel and bin
    // address is pixel over bin
    logic [countBits-1:0] mem [depth];

    always_ff @(posedge clk) begin
        if (wrEn) begin
            mem[wrAddr] <= wrData;
        end
    end

    // registered read so data lands one cycle after rdEn
    always_ff @(posedge clk) begin
        if (rdEn) begin
            rdData <= mem[rdAddr];
        end
    end

endmodule

`default_nettype wire

// ==== hw/histogramFsm.sv ====
`default_nettype none

module histogramFsm #(
    parameter int pixelCount = 4,
    parameter int binBits = sifhPkg::binBitsDef,
    parameter int countBits = sifhPkg::countBitsDef,
    parameter int stampsPerPixel = 20,
    localparam int addrBits = $clog2(pixelCount) + binBits
) (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic                 entryValid,
    input  wire sifhPkg::stampEntry   entry,
    output logic                      pop,
    output logic                      ready,
    output logic                      ramRdEn,
    output logic [addrBits-1:0]       ramRdAddr,
    input  wire logic [countBits-1:0] ramRdData,
    output logic                      ramWrEn,
    output logic [addrBits-1:0]       ramWrAddr,
    output logic [countBits-1:0]      ramWrData,
    output logic                      peakValid,
    output sifhPkg::peakReport        peak,
    input  wire logic                 peakReady
);
    import sifhPkg::*;

    localparam int pixBits = $clog2(pixelCount);
    localparam int tallyBits = $clog2(stampsPerPixel);
    localparam logic [addrBits-1:0] clearLast = addrBits'((pixelCount << binBits) - 1);
    localparam logic [binBits-1:0] binLast = '1;
    localparam logic [countBits-1:0] countMax = '1;
    localparam logic [tallyBits-1:0] tallyLast = tallyBits'(stampsPerPixel - 1);

    histState_e state;
    logic clearDone;
    logic [addrBits-1:0] clearAddr;
    logic [pixBits-1:0] pixQ;
    logic [binBits-1:0] binQ;
    logic [tallyBits-1:0] tally [pixelCount];
    logic [binBits-1:0] scanBin;
    logic [binBits-1:0] maxBin;
    logic [countBits-1:0] maxCount;
    logic [countBits-1:0] bumped;
    logic lastStamp;
    logic takeNew;
    logic [binBits-1:0] winBin;
    logic [countBits-1:0] winCount;

    // ingest held off until every word is zero
    assign ready = clearDone;
    // entries only leave the FIFO from idle
    assign pop = (state == idle) && clearDone && entryValid;
    assign peakValid = (state == report);

    // saturating increment
    assign bumped = (ramRdData == countMax) ? ramRdData : ramRdData + 1'b1;
    assign lastStamp = tally[pixQ] == tallyLast;

    // strict compare so a tie keeps the lower bin
    assign takeNew = ramRdData > maxCount;
    assign winBin = takeNew ? scanBin : maxBin;
    assign winCount = takeNew ? ramRdData : maxCount;

    // read port
    always_comb begin
        ramRdEn = 1'b0;
        ramRdAddr = {pixQ, binQ};
        case (state)
            readBin: ramRdEn = 1'b1;
            sweepRead: begin
                ramRdEn = 1'b1;
                ramRdAddr = {pixQ, {binBits{1'b0}}};
            end
            // fetch one bin ahead of the compare
            sweepScan: begin
                ramRdEn = scanBin != binLast;
                ramRdAddr = {pixQ, scanBin + 1'b1};
            end
            default: ramRdEn = 1'b0;
        endcase
    end

    // write port
    always_comb begin
        ramWrEn = 1'b0;
        ramWrAddr = {pixQ, binQ};
        ramWrData = bumped;
        if (!clearDone) begin
            ramWrEn = 1'b1;
            ramWrAddr = clearAddr;
            ramWrData = '0;
        end else if (state == updateBin) begin
            ramWrEn = 1'b1;
        end else if (state == sweepScan) begin
            // each bin zeroed right after it is compared
            ramWrEn = 1'b1;
            ramWrAddr = {pixQ, scanBin};
            ramWrData = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= idle;
            clearDone <= 1'b0;
            clearAddr <= '0;
        end else begin
            // walk the whole RAM once after reset
            if (!clearDone) begin
                clearAddr <= clearAddr + 1'b1;
                if (clearAddr == clearLast) begin
                    clearDone <= 1'b1;
                end
            end
            case (state)
                idle: if (pop) state <= readBin;
                readBin: state <= updateBin;
                updateBin: state <= lastStamp ? sweepRead : idle;
                sweepRead: state <= sweepScan;
                sweepScan: if (scanBin == binLast) state <= report;
                report: if (peakReady) state <= idle;
                default: state <= idle;
            endcase
        end
    end

    // stamps seen per pixel in the current acquisition
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int p = 0; p < pixelCount; p++) begin
                tally[p] <= '0;
            end
        end else if (state == updateBin) begin
            tally[pixQ] <= lastStamp ? '0 : tally[pixQ] + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            pixQ <= pixBits'(entry.pixel);
            binQ <= binBits'(entry.bin);
        end
        // running maximum over the sweep
        if (state == sweepRead) begin
            scanBin <= '0;
            maxBin <= '0;
            maxCount <= '0;
        end else if (state == sweepScan) begin
            scanBin <= scanBin + 1'b1;
            maxBin <= winBin;
            maxCount <= winCount;
        end
        // report latched once on the last bin
        if (state == sweepScan && scanBin == binLast) begin
            peak.pixel <= pixelBitsDef'(pixQ);
            peak.bin <= binBitsDef'(winBin);
            peak.count <= countBitsDef'(winCount);
        end
    end

    // report held steady under back-pressure
    assert property (@(posedge clk) disable iff (rst)
        peakValid && !peakReady |=> peakValid && $stable(peak))
        else $error("histogramFsm peak report changed while stalled");

endmodule

`default_nettype wire

// ==== hw/sifhPkg.sv ====
`default_nettype none

package sifhPkg;

    // default widths
    // the top level sets its parameters to these same values
    localparam int pixelBitsDef = 2;
    localparam int binBitsDef = 6;
    localparam int stampBitsDef = 10;
    localparam int countBitsDef = 4;

    // write response codes
    typedef enum logic [1:0] {
        respOkay   = 2'b00,
        respSlvErr = 2'b10
    } bresp_e;

    // histogram engine states
    typedef enum logic [2:0] {
        idle,
        readBin,
        updateBin,
        sweepRead,
        sweepScan,
        report
    } histState_e;

    // host side of the AXI4-Lite write channel
    typedef struct packed {
        logic        awvalid;
        logic [31:0] awaddr;
        logic        wvalid;
        logic [31:0] wdata;
        logic        bready;
    } axiWrReq;

    // subsystem side of the write channel
    typedef struct packed {
        logic   awready;
        logic   wready;
        logic   bvalid;
        bresp_e bresp;
    } axiWrRsp;

    // one photon arrival after binning
    typedef struct packed {
        logic [pixelBitsDef-1:0] pixel;
        logic [binBitsDef-1:0]   bin;
    } stampEntry;

    // result of one finished acquisition
    typedef struct packed {
        logic [pixelBitsDef-1:0] pixel;
        logic [binBitsDef-1:0]   bin;
        logic [countBitsDef-1:0] count;
    } peakReport;

endpackage

`default_nettype wire

// ==== hw/sifhTop.sv ====
`default_nettype none

module sifhTop #(
    parameter int pixelCount = 4,
    parameter int binBits = 6,
    parameter int stampBits = 10,
    parameter int countBits = 4,
    parameter int stampsPerPixel = 20,
    parameter int fifoDepth = 8
) (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire sifhPkg::axiWrReq  axiReq,
    output sifhPkg::axiWrRsp       axiRsp,
    output logic                   peakValid,
    output sifhPkg::peakReport     peak,
    input  wire logic              peakReady
);
    import sifhPkg::*;

    localparam int addrBits = $clog2(pixelCount) + binBits;

    stampEntry pushEntry;
    stampEntry popEntry;
    logic push;
    logic pop;
    logic fifoFull;
    logic fifoEmpty;
    logic ready;
    logic ramRdEn;
    logic ramWrEn;
    logic [addrBits-1:0] ramRdAddr;
    logic [addrBits-1:0] ramWrAddr;
    logic [countBits-1:0] ramRdData;
    logic [countBits-1:0] ramWrData;

    // host writes become stamp entries
    stampIngest #(
        .pixelCount(pixelCount),
        .binBits(binBits),
        .stampBits(stampBits)
    ) i_ingest (
        .clk(clk),
        .rst(rst),
        .axiReq(axiReq),
        .axiRsp(axiRsp),
        .fifoFull(fifoFull),
        .ready(ready),
        .push(push),
        .entry(pushEntry)
    );

    stampFifo #(
        .fifoDepth(fifoDepth)
    ) i_fifo (
        .clk(clk),
        .rst(rst),
        .push(push),
        .pushEntry(pushEntry),
        .full(fifoFull),
        .pop(pop),
        .popEntry(popEntry),
        .empty(fifoEmpty)
    );

    // update, sweep and report engine
    histogramFsm #(
        .pixelCount(pixelCount),
        .binBits(binBits),
        .countBits(countBits),
        .stampsPerPixel(stampsPerPixel)
    ) i_fsm (
        .clk(clk),
        .rst(rst),
        .entryValid(!fifoEmpty),
        .entry(popEntry),
        .pop(pop),
        .ready(ready),
        .ramRdEn(ramRdEn),
        .ramRdAddr(ramRdAddr),
        .ramRdData(ramRdData),
        .ramWrEn(ramWrEn),
        .ramWrAddr(ramWrAddr),
        .ramWrData(ramWrData),
        .peakValid(peakValid),
        .peak(peak),
        .peakReady(peakReady)
    );

    histRam #(
        .pixelCount(pixelCount),
        .binBits(binBits),
        .countBits(countBits)
    ) i_ram (
        .clk(clk),
        .rdEn(ramRdEn),
        .rdAddr(ramRdAddr),
        .rdData(ramRdData),
        .wrEn(ramWrEn),
        .wrAddr(ramWrAddr),
        .wrData(ramWrData)
    );

endmodule

`default_nettype wire

// ==== hw/stampFifo.sv ====
`default_nettype none

module stampFifo #(
    parameter int fifoDepth = 8
) (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire logic               push,
    input  wire sifhPkg::stampEntry pushEntry,
    output logic                    full,
    input  wire logic               pop,
    output sifhPkg::stampEntry      popEntry,
    output logic                    empty
);
    import sifhPkg::*;

    localparam int ptrBits = $clog2(fifoDepth);
    localparam logic [ptrBits-1:0] lastSlot = ptrBits'(fifoDepth - 1);

    stampEntry mem [fifoDepth];
    logic [ptrBits-1:0] wrPtr;
    logic [ptrBits-1:0] rdPtr;
    logic [ptrBits:0] used;
    logic doPush;
    logic doPop;

    assign doPush = push && !full;
    assign doPop = pop && !empty;
    assign full = used == (ptrBits + 1)'(fifoDepth);
    assign empty = used == '0;
    // head entry visible without a read cycle
    assign popEntry = mem[rdPtr];

    always_ff @(posedge clk) begin
        if (doPush) begin
            mem[wrPtr] <= pushEntry;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            used <= '0;
        end else begin
            // pointers wrap at the last slot
            if (doPush) begin
                wrPtr <= (wrPtr == lastSlot) ? '0 : wrPtr + 1'b1;
            end
            if (doPop) begin
                rdPtr <= (rdPtr == lastSlot) ? '0 : rdPtr + 1'b1;
            end
            // occupancy unchanged on simultaneous push and pop
            case ({doPush, doPop})
                2'b10: used <= used + 1'b1;
                2'b01: used <= used - 1'b1;
                default: used <= used;
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (rst) pop |-> !empty)
        else $error("stampFifo pop while empty");
    assert property (@(posedge clk) disable iff (rst) push |-> !full)
        else $error("stampFifo push while full");

endmodule

`default_nettype wire

// ==== hw/stampIngest.sv ====
`default_nettype none

module stampIngest #(
    parameter int pixelCount = 4,
    parameter int binBits = sifhPkg::binBitsDef,
    parameter int stampBits = sifhPkg::stampBitsDef
) (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire sifhPkg::axiWrReq  axiReq,
    output sifhPkg::axiWrRsp       axiRsp,
    input  wire logic              fifoFull,
    input  wire logic              ready,
    output logic                   push,
    output sifhPkg::stampEntry     entry
);
    import sifhPkg::*;

    logic [29:0] wordAddr;
    logic [stampBits-1:0] stamp;
    logic inRange;
    logic accept;
    logic bvalidQ;
    bresp_e brespQ;

    // word address selects the pixel
    assign wordAddr = axiReq.awaddr[31:2];
    assign inRange = wordAddr < 30'(pixelCount);
    // only the low timestamp bits are meaningful
    assign stamp = axiReq.wdata[stampBits-1:0];

    // address and data beats taken together in one cycle
    // held off during the RAM clear and while a response waits
    assign accept = axiReq.awvalid && axiReq.wvalid && !fifoFull && !bvalidQ && ready;

    // out of range writes are answered but never queued
    assign push = accept && inRange;

    always_comb begin
        entry.pixel = wordAddr[pixelBitsDef-1:0];
        // bin is the top binBits of the timestamp
        entry.bin = binBitsDef'(stamp >> (stampBits - binBits));
    end

    always_comb begin
        axiRsp.awready = accept;
        axiRsp.wready = accept;
        axiRsp.bvalid = bvalidQ;
        axiRsp.bresp = brespQ;
    end

    // response valid until the host takes it
    always_ff @(posedge clk) begin
        if (rst) begin
            bvalidQ <= 1'b0;
        end else if (accept) begin
            bvalidQ <= 1'b1;
        end else if (axiReq.bready) begin
            bvalidQ <= 1'b0;
        end
    end

    // response code captured with the transfer
    always_ff @(posedge clk) begin
        if (accept) begin
            brespQ <= inRange ? respOkay : respSlvErr;
        end
    end

endmodule

`default_nettype wire

// ==== testbench/sifhTb.sv ====
`default_nettype none

module sifhTb;
    timeunit 1ns;
    timeprecision 100ps;

    import sifhPkg::*;

    localparam int pixelCount = 4;
    localparam int binBits = 6;
    localparam int stampBits = 10;
    localparam int countBits = 4;
    localparam int stampsPerPixel = 20;
    localparam int fifoDepth = 8;
    localparam int binCount = 1 << binBits;
    localparam int shiftBits = stampBits - binBits;
    localparam int stampMask = (1 << stampBits) - 1;
    localparam int lowMask = (1 << shiftBits) - 1;
    localparam int countMax = (1 << countBits) - 1;
    localparam int writeTimeout = 400;
    localparam int respTimeout = 10;
    localparam int reportTimeout = 2000;
    localparam int rowCount = 7;

    // stamp generator kinds
    localparam int genSpread = 0;
    localparam int genTie = 1;
    localparam int genRepeat = 2;
    localparam int genBad = 3;
    localparam int genRandom = 4;

    typedef struct {
        string name;
        int    pixel;
        int    kind;
        int    stall;
    } testRow;

    // one row per acquisition applied in order
    testRow rows [rowCount] = '{
        '{"spread", 0, genSpread, 0},
        '{"tie", 1, genTie, 2},
        '{"saturate", 2, genRepeat, 0},
        '{"badPixel", 3, genBad, 1},
        '{"reacquire", 0, genRandom, 0},
        '{"stall", 1, genRandom, 80},
        '{"afterStall", 2, genRandom, 0}
    };

    logic clk = 1'b0;
    logic rst;
    axiWrReq axiReq;
    axiWrRsp axiRsp;
    logic peakValid;
    peakReport peak;
    logic peakReady;

    int seed = 32'h86a3_dde0;
    int modelCount [pixelCount][binCount];
    peakReport expPeak [rowCount];
    int opPixel [$];
    int opStamp [$];
    int opRow [$];
    int passCount = 0;
    int failCount = 0;
    int maxWait = 0;
    bit aborted = 1'b0;

    sifhTop #(
        .pixelCount(pixelCount),
        .binBits(binBits),
        .stampBits(stampBits),
        .countBits(countBits),
        .stampsPerPixel(stampsPerPixel),
        .fifoDepth(fifoDepth)
    ) i_dut (
        .clk(clk),
        .rst(rst),
        .axiReq(axiReq),
        .axiRsp(axiRsp),
        .peakValid(peakValid),
        .peak(peak),
        .peakReady(peakReady)
    );

    always #5 clk = ~clk;

    function automatic int makeStamp(input int kind, input int i);
        int bin;
        bin = 0;
        case (kind)
            genSpread: bin = (i < 8) ? 40 : 2 + i % 9;
            // higher bin fills first and the lower bin must still win
            genTie: bin = (i < 8) ? 30 : ((i < 16) ? 12 : 50);
            genRepeat: bin = 7;
            genBad: bin = (i % 5 == 0) ? 61 : 18 + i % 3;
            default: return $random(seed) & stampMask;
        endcase
        // low bits below the bin vary and are dropped by the binning
        return (bin << shiftBits) | (i & lowMask);
    endfunction

    // write list and expected reports from the binning and peak rules
    task automatic buildModel();
        int s;
        int b;
        int p;
        int best;
        int bestBin;
        for (int r = 0; r < rowCount; r++) begin
            p = rows[r].pixel;
            for (int i = 0; i < stampsPerPixel; i++) begin
                if (rows[r].kind == genBad) begin
                    // out of range pixel is never counted anywhere
                    opPixel.push_back(pixelCount + i % 4);
                    opStamp.push_back(stampMask - i);
                    opRow.push_back(r);
                end
                s = makeStamp(rows[r].kind, i);
                opPixel.push_back(p);
                opStamp.push_back(s);
                opRow.push_back(r);
                b = s >> shiftBits;
                if (modelCount[p][b] < countMax) begin
                    modelCount[p][b]++;
                end
            end
            // strict greater keeps the lowest bin and each bin is cleared
            best = 0;
            bestBin = 0;
            for (int k = 0; k < binCount; k++) begin
                if (modelCount[p][k] > best) begin
                    best = modelCount[p][k];
                    bestBin = k;
                end
                modelCount[p][k] = 0;
            end
            expPeak[r].pixel = pixelBitsDef'(p);
            expPeak[r].bin = binBitsDef'(bestBin);
            expPeak[r].count = countBitsDef'(best);
        end
    endtask

    // one AXI4-Lite write with address and data beats together
    task automatic hostWrite(input int pixel, input int stamp, input string name,
                             output int waited);
        bresp_e expResp;
        expResp = (pixel < pixelCount) ? respOkay : respSlvErr;
        @(negedge clk);
        axiReq.awvalid = 1'b1;
        axiReq.awaddr = 32'(pixel << 2);
        axiReq.wvalid = 1'b1;
        axiReq.wdata = 32'(stamp);
        waited = 0;
        // awready is combinational on the valids so let it settle
        #1;
        while (!axiRsp.awready && waited < writeTimeout) begin
            @(negedge clk);
            #1;
            waited++;
        end
        if (!axiRsp.awready) begin
            $display("%s: write to pixel %0d was never accepted", name, pixel);
            failCount++;
            aborted = 1'b1;
            axiReq.awvalid = 1'b0;
            axiReq.wvalid = 1'b0;
            return;
        end
        assert (axiRsp.wready) else begin
            $display("%s: wready did not rise together with awready", name);
            failCount++;
        end
        @(negedge clk);
        axiReq.awvalid = 1'b0;
        axiReq.wvalid = 1'b0;
        for (int t = 0; t < respTimeout && !axiRsp.bvalid; t++) begin
            @(negedge clk);
        end
        if (!axiRsp.bvalid) begin
            $display("%s: no write response for pixel %0d", name, pixel);
            failCount++;
            aborted = 1'b1;
            return;
        end
        assert (axiRsp.bresp == expResp) else begin
            $display("Fail %s bresp expected %0d actual %0d", name, expResp, axiRsp.bresp);
            failCount++;
        end
        axiReq.bready = 1'b1;
        @(negedge clk);
        axiReq.bready = 1'b0;
    endtask

    task automatic runWriter();
        int waited;
        for (int k = 0; k < opPixel.size(); k++) begin
            if (!aborted) begin
                hostWrite(opPixel[k], opStamp[k], rows[opRow[k]].name, waited);
                // first write also sits out the RAM clear
                if (k > 0 && waited > maxWait) begin
                    maxWait = waited;
                end
            end
        end
    endtask

    // wait for a report, check it, then hold peakReady low for the stall
    task automatic collectReport(input int r);
        int waited;
        bit ok;
        peakReport exp;
        exp = expPeak[r];
        waited = 0;
        @(negedge clk);
        while (!peakValid && waited < reportTimeout) begin
            @(negedge clk);
            waited++;
        end
        if (!peakValid) begin
            $display("%s: no peak report within %0d cycles", rows[r].name, reportTimeout);
            failCount++;
            aborted = 1'b1;
            return;
        end
        ok = (peak === exp);
        assert (ok) else begin
            $display("Fail %s expected pix %0d bin %0d cnt %0d actual pix %0d bin %0d cnt %0d",
                     rows[r].name, exp.pixel, exp.bin, exp.count,
                     peak.pixel, peak.bin, peak.count);
            failCount++;
        end
        if (ok) begin
            $display("ok %s pixel %0d bin %0d count %0d", rows[r].name,
                     peak.pixel, peak.bin, peak.count);
            passCount++;
        end
        repeat (rows[r].stall) @(negedge clk);
        peakReady = 1'b1;
        @(negedge clk);
        peakReady = 1'b0;
    endtask

    task automatic runReader();
        for (int r = 0; r < rowCount; r++) begin
            if (!aborted) begin
                collectReport(r);
            end
        end
    endtask

    initial begin
        axiReq = '0;
        peakReady = 1'b0;
        rst = 1'b1;
        buildModel();
        repeat (5) @(negedge clk);
        rst = 1'b0;
        fork
            runWriter();
            runReader();
        join
        // the long stall must have held the host off for a while
        assert (maxWait >= 40) else begin
            $display("awready was never held off during the report stall");
            failCount++;
        end
        if (maxWait >= 40) begin
            $display("ok backpressure longest wait %0d cycles", maxWait);
            passCount++;
        end
        $display("tests passed %0d, checks failed %0d", passCount, failCount);
        if (failCount == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire
